//--- Bender.yml
package:
  name: mem_access

sources:
  - mem_pkg.sv
  - mem_align.sv
  - spm.sv
  - ahb_access_fsm.sv
  - bus_wait_timer.sv
  - mem_access_top.sv
  - target: test
    files:
      - tb_ahb_slave.sv
      - tb_mem_access.sv

//--- ahb_access_fsm.sv
`timescale 1ns/1ps

module ahb_access_fsm import mem_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req_valid,
    input  mem_op_t   op,
    input  logic      misaligned,
    input  logic      spm_sel,
    input  logic      hready,
    input  logic      hresp,
    input  logic      timeout,
    output logic      spm_rden,
    output logic      spm_wren,
    output htrans_t   htrans,
    output logic      hwrite,
    output logic      data_phase,
    output logic      timer_run,
    output logic      done,
    output exp_code_t exp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SPM_ACCESS,
        ST_EXCEPTION,
        ST_ADDR_PHASE,
        ST_DATA_PHASE,
        ST_FINISH
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   is_store;
    logic   spm_go;

    assign is_store = op inside {OP_SB, OP_SH, OP_SW};

    // scratchpad is touched on the accepting edge itself
    assign spm_go = (state_q == ST_IDLE) && req_valid && !misaligned && spm_sel;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid) begin
                    if (misaligned) begin
                        state_d = ST_EXCEPTION;
                    end else if (spm_sel) begin
                        state_d = ST_SPM_ACCESS;
                    end else begin
                        state_d = ST_ADDR_PHASE;
                    end
                end
            end
            ST_ADDR_PHASE: begin
                state_d = ST_DATA_PHASE;
            end
            ST_DATA_PHASE: begin
                // hready wins over a timeout in the same cycle
                if (hready) begin
                    state_d = ST_IDLE;
                end else if (timeout) begin
                    state_d = ST_FINISH;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign spm_rden   = spm_go && !is_store;
    assign spm_wren   = spm_go && is_store;
    assign htrans     = (state_q == ST_ADDR_PHASE) ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign hwrite     = (state_q == ST_ADDR_PHASE) && is_store;
    assign data_phase = (state_q == ST_DATA_PHASE);
    assign timer_run  = data_phase;

    assign done = (state_q == ST_SPM_ACCESS) || (state_q == ST_EXCEPTION) ||
                  (state_q == ST_FINISH) || (data_phase && hready);

    always_comb begin
        exp = EXP_NONE;
        if (state_q == ST_EXCEPTION) begin
            exp = is_store ? EXP_STORE_MISALIGNED : EXP_LOAD_MISALIGNED;
        end else if ((state_q == ST_FINISH) || (data_phase && hready && hresp)) begin
            // error response or stuck slave
            exp = is_store ? EXP_STORE_ACCESS_FAULT : EXP_LOAD_ACCESS_FAULT;
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    a_single_nonseq: assert property (@(posedge clk) disable iff (!arst_n)
        (htrans == HTRANS_NONSEQ) |=> (htrans == HTRANS_IDLE) && data_phase)
        else $error("nonseq not followed by a data phase");

endmodule

//--- build.f
mem_pkg.sv
mem_align.sv
spm.sv
ahb_access_fsm.sv
bus_wait_timer.sv
mem_access_top.sv
tb_ahb_slave.sv
tb_mem_access.sv

//--- bus_wait_timer.sv
`timescale 1ns/1ps

module bus_wait_timer #(
    parameter int BUS_TIMEOUT = 16
) (
    input  logic clk,
    input  logic arst_n,
    input  logic run,
    output logic timeout
);

    localparam int CNT_W = $clog2(BUS_TIMEOUT + 1);

    logic [CNT_W-1:0] count;

    // saturates at the limit until run drops
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count != CNT_W'(BUS_TIMEOUT)) begin
            count <= count + 1'b1;
        end
    end

    assign timeout = (count == CNT_W'(BUS_TIMEOUT));

    a_count_limit: assert property (@(posedge clk) disable iff (!arst_n)
        count <= CNT_W'(BUS_TIMEOUT))
        else $error("bus wait count past its limit");

endmodule

//--- mem_access_top.sv
`timescale 1ns/1ps

module mem_access_top import mem_pkg::*; #(
    parameter int SPM_DEPTH   = 256,
    parameter int BUS_TIMEOUT = 16
) (
    input  logic     clk,
    input  logic     arst_n,
    input  mem_req_t req,
    output mem_rsp_t rsp,
    output logic     bus_wait,
    output ahb_m2s_t ahb_out,
    input  ahb_s2m_t ahb_in,
    output hsize_t   hburst,
    output logic     hmastlock
);

    logic      misaligned;
    logic      spm_sel;
    byteena_t  byteena;
    word_t     wdata;
    hsize_t    hsize;
    word_t     load_data;
    word_t     rdata_raw;
    word_t     spm_rdata;
    logic      spm_rden;
    logic      spm_wren;
    htrans_t   htrans;
    logic      hwrite;
    logic      data_phase;
    logic      timer_run;
    logic      timeout;
    logic      done;
    exp_code_t exp;
    word_t     addr_q;
    word_t     wdata_q;

    mem_align u_mem_align (
        .req        (req        ),
        .rdata_raw  (rdata_raw  ),
        .misaligned (misaligned ),
        .spm_sel    (spm_sel    ),
        .byteena    (byteena    ),
        .wdata      (wdata      ),
        .hsize      (hsize      ),
        .load_data  (load_data  )
    );

    spm #(
        .SPM_DEPTH (SPM_DEPTH)
    ) u_spm (
        .clk       (clk                     ),
        .word_addr ({2'b00, req.addr[31:2]} ),
        .rden      (spm_rden                ),
        .wren      (spm_wren                ),
        .byteena   (byteena                 ),
        .wdata     (wdata                   ),
        .rdata     (spm_rdata               )
    );

    ahb_access_fsm u_ahb_access_fsm (
        .clk        (clk            ),
        .arst_n     (arst_n         ),
        .req_valid  (req.valid      ),
        .op         (req.op         ),
        .misaligned (misaligned     ),
        .spm_sel    (spm_sel        ),
        .hready     (ahb_in.hready  ),
        .hresp      (ahb_in.hresp   ),
        .timeout    (timeout        ),
        .spm_rden   (spm_rden       ),
        .spm_wren   (spm_wren       ),
        .htrans     (htrans         ),
        .hwrite     (hwrite         ),
        .data_phase (data_phase     ),
        .timer_run  (timer_run      ),
        .done       (done           ),
        .exp        (exp            )
    );

    bus_wait_timer #(
        .BUS_TIMEOUT (BUS_TIMEOUT)
    ) u_bus_wait_timer (
        .clk     (clk       ),
        .arst_n  (arst_n    ),
        .run     (timer_run ),
        .timeout (timeout   )
    );

    // frozen during the data phase, the request is stable before that
    always_ff @(posedge clk) begin
        if (!data_phase) begin
            addr_q  <= req.addr;
            wdata_q <= wdata;
        end
    end

    assign rdata_raw = spm_sel ? spm_rdata : ahb_in.hrdata;

    assign ahb_out = '{
        haddr:  addr_q,
        hwrite: hwrite,
        hsize:  hsize,
        htrans: htrans,
        hwdata: wdata_q
    };

    // single transfers only, never locked
    assign hburst    = '0;
    assign hmastlock = 1'b0;

    assign rsp = '{done: done, load_data: load_data, exp: exp};

    assign bus_wait = req.valid && !done;

endmodule

//--- mem_align.sv
`timescale 1ns/1ps

module mem_align import mem_pkg::*; (
    input  mem_req_t req,
    input  word_t    rdata_raw,
    output logic     misaligned,
    output logic     spm_sel,
    output byteena_t byteena,
    output word_t    wdata,
    output hsize_t   hsize,
    output word_t    load_data
);

    logic  size_byte;
    logic  size_half;
    logic  size_word;
    word_t rdata_shift;

    assign size_byte = req.op inside {OP_LB, OP_LBU, OP_SB};
    assign size_half = req.op inside {OP_LH, OP_LHU, OP_SH};
    assign size_word = req.op inside {OP_LW, OP_SW};

    // half needs bit 0 clear, word needs both low bits clear
    assign misaligned = (size_half && req.addr[0]) ||
                        (size_word && (req.addr[1:0] != 2'b00));

    assign spm_sel = (req.addr[31:28] == SPM_REGION);

    // store data is replicated so every lane carries the right bytes
    always_comb begin
        if (size_byte) begin
            byteena = 4'b0001 << req.addr[1:0];
            wdata   = {4{req.store_data[7:0]}};
            hsize   = HSIZE_BYTE;
        end else if (size_half) begin
            byteena = req.addr[1] ? 4'b1100 : 4'b0011;
            wdata   = {2{req.store_data[15:0]}};
            hsize   = HSIZE_HALF;
        end else begin
            byteena = 4'b1111;
            wdata   = req.store_data;
            hsize   = HSIZE_WORD;
        end
    end

    // move the addressed lane down to bit 0
    assign rdata_shift = rdata_raw >> {req.addr[1:0], 3'b000};

    always_comb begin
        case (req.op)
            OP_LB: begin
                load_data = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
            end
            OP_LBU: begin
                load_data = {24'h000000, rdata_shift[7:0]};
            end
            OP_LH: begin
                load_data = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
            end
            OP_LHU: begin
                load_data = {16'h0000, rdata_shift[15:0]};
            end
            OP_LW: begin
                load_data = rdata_raw;
            end
            // stores return nothing
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byteena_t;
    typedef logic [2:0]  hsize_t;

    // loads first, stores last
    typedef enum logic [2:0] {
        OP_LB, OP_LH, OP_LW, OP_LBU,
        OP_LHU, OP_SB, OP_SH, OP_SW
    } mem_op_t;

    typedef enum logic [2:0] {
        EXP_NONE,
        EXP_LOAD_MISALIGNED,
        EXP_STORE_MISALIGNED,
        EXP_LOAD_ACCESS_FAULT,
        EXP_STORE_ACCESS_FAULT
    } exp_code_t;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_t;

    localparam hsize_t HSIZE_BYTE = 3'b000;
    localparam hsize_t HSIZE_HALF = 3'b001;
    localparam hsize_t HSIZE_WORD = 3'b010;

    // top nibble of the address that selects the scratchpad
    localparam logic [3:0] SPM_REGION = 4'h1;

    typedef struct packed {
        logic    valid;
        mem_op_t op;
        word_t   addr;
        word_t   store_data;
    } mem_req_t;

    typedef struct packed {
        logic      done;
        word_t     load_data;
        exp_code_t exp;
    } mem_rsp_t;

    typedef struct packed {
        word_t   haddr;
        logic    hwrite;
        hsize_t  hsize;
        htrans_t htrans;
        word_t   hwdata;
    } ahb_m2s_t;

    typedef struct packed {
        word_t hrdata;
        logic  hready;
        logic  hresp;
    } ahb_s2m_t;

endpackage

//--- spm.sv
`timescale 1ns/1ps

module spm import mem_pkg::*; #(
    parameter int SPM_DEPTH = 256
) (
    input  logic     clk,
    input  word_t    word_addr,
    input  logic     rden,
    input  logic     wren,
    input  byteena_t byteena,
    input  word_t    wdata,
    output word_t    rdata
);

    localparam int IDX_W = $clog2(SPM_DEPTH);

    word_t            mem [SPM_DEPTH];
    logic [IDX_W-1:0] idx;

    // upper address bits alias onto the array
    assign idx = word_addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (wren) begin
            for (int i = 0; i < 4; i++) begin
                if (byteena[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        if (rden) begin
            rdata <= mem[idx];
        end
    end

    // single port, one access per cycle
    a_one_port: assert property (@(posedge clk) !(rden && wren))
        else $error("spm read and write in the same cycle");

endmodule

//--- tb_ahb_slave.sv
`timescale 1ns/1ps

module tb_ahb_slave import mem_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  ahb_m2s_t   m2s,
    input  logic [7:0] wait_cycles,
    input  logic       err,
    output ahb_s2m_t   s2m
);

    word_t      mem [64];
    logic       dp;
    logic [8:0] cnt;
    logic       err_q;
    logic       write_q;
    word_t      addr_q;
    hsize_t     size_q;
    logic [5:0] idx;
    logic [3:0] lanes;

    // every word starts as its own byte address with a tag on top
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h5a5a_0000 | (i << 2);
        end
    end

    assign idx = addr_q[7:2];

    always_comb begin
        case (size_q)
            HSIZE_BYTE: lanes = 4'b0001 << addr_q[1:0];
            HSIZE_HALF: lanes = addr_q[1] ? 4'b1100 : 4'b0011;
            default:    lanes = 4'b1111;
        endcase
    end

    // cnt holds the low-ready cycles still to go, an error adds one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dp      <= 1'b0;
            cnt     <= '0;
            err_q   <= 1'b0;
            write_q <= 1'b0;
            addr_q  <= '0;
            size_q  <= HSIZE_BYTE;
        end else if (m2s.htrans == HTRANS_NONSEQ) begin
            // a new address phase also replaces a stuck transfer
            dp      <= 1'b1;
            cnt     <= 9'(wait_cycles) + 9'(err);
            err_q   <= err;
            write_q <= m2s.hwrite;
            addr_q  <= m2s.haddr;
            size_q  <= m2s.hsize;
        end else if (dp) begin
            if (cnt == 0) begin
                dp <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (dp && s2m.hready && write_q && !err_q) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    mem[idx][8*i +: 8] <= m2s.hwdata[8*i +: 8];
                end
            end
        end
    end

    // two-cycle error: hresp with hready low, then with hready high
    assign s2m = '{
        hrdata: mem[idx],
        hready: !dp || (cnt == 0),
        hresp:  dp && err_q && (cnt <= 1)
    };

endmodule

//--- tb_mem_access.sv
`timescale 1ns/1ps

module tb_mem_access import mem_pkg::*; ();

    localparam int SPM_DEPTH   = 256;
    localparam int BUS_TIMEOUT = 16;

    typedef struct packed {
        mem_op_t    op;
        word_t      addr;
        word_t      sdata;
        logic [7:0] waits;
        logic       err;
        word_t      load;
        exp_code_t  exp;
    } vector_t;

    logic       clk;
    logic       arst_n;
    mem_req_t   req;
    mem_rsp_t   rsp;
    logic       bus_wait;
    ahb_m2s_t   ahb_out;
    ahb_s2m_t   ahb_in;
    hsize_t     hburst;
    logic       hmastlock;
    logic [7:0] slave_waits;
    logic       slave_err;
    vector_t    vectors [$];

    mem_access_top #(
        .SPM_DEPTH   (SPM_DEPTH  ),
        .BUS_TIMEOUT (BUS_TIMEOUT)
    ) uut (
        .clk       (clk      ),
        .arst_n    (arst_n   ),
        .req       (req      ),
        .rsp       (rsp      ),
        .bus_wait  (bus_wait ),
        .ahb_out   (ahb_out  ),
        .ahb_in    (ahb_in   ),
        .hburst    (hburst   ),
        .hmastlock (hmastlock)
    );

    tb_ahb_slave u_slave (
        .clk         (clk        ),
        .arst_n      (arst_n     ),
        .m2s         (ahb_out    ),
        .wait_cycles (slave_waits),
        .err         (slave_err  ),
        .s2m         (ahb_in     )
    );

    always #4 clk = ~clk;

    function automatic void add_vector(mem_op_t op, word_t addr, word_t sdata, int waits,
                                       logic err, word_t load, exp_code_t exp);
        vectors.push_back('{op, addr, sdata, 8'(waits), err, load, exp});
    endfunction

    function automatic logic is_store_op(mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic hsize_t size_of(mem_op_t op);
        if (op inside {OP_LB, OP_LBU, OP_SB}) begin
            return HSIZE_BYTE;
        end else if (op inside {OP_LH, OP_LHU, OP_SH}) begin
            return HSIZE_HALF;
        end
        return HSIZE_WORD;
    endfunction

    // store bytes repeated on every lane
    function automatic word_t lane_data(hsize_t size, word_t d);
        case (size)
            HSIZE_BYTE: return {4{d[7:0]}};
            HSIZE_HALF: return {2{d[15:0]}};
            default:    return d;
        endcase
    endfunction

    task automatic check_equal(string name, word_t got, word_t want);
        if (got !== want) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        vector_t v;
        hsize_t  size;
        logic    bad_align;
        logic    to_spm;
        logic    stuck;
        int      lat;
        int      want_lat;
        logic    saw_nonseq;

        clk         = 1'b0;
        arst_n      = 1'b0;
        req         = '0;
        slave_waits = '0;
        slave_err   = 1'b0;

        // op, addr, store data, waits, error, load data, exception
        add_vector(OP_SW,  32'h1000_0010, 32'h8765_4321, 0, 0, 32'h0, EXP_NONE);
        add_vector(OP_SB,  32'h1000_0011, 32'h0000_00f0, 0, 0, 32'h0, EXP_NONE);
        add_vector(OP_SH,  32'h1000_0012, 32'h0000_9abc, 0, 0, 32'h0, EXP_NONE);
        add_vector(OP_LW,  32'h1000_0010, 32'h0, 0, 0, 32'h9abc_f021, EXP_NONE);
        add_vector(OP_LB,  32'h1000_0011, 32'h0, 0, 0, 32'hffff_fff0, EXP_NONE);
        add_vector(OP_LBU, 32'h1000_0011, 32'h0, 0, 0, 32'h0000_00f0, EXP_NONE);
        add_vector(OP_LB,  32'h1000_0010, 32'h0, 0, 0, 32'h0000_0021, EXP_NONE);
        add_vector(OP_LH,  32'h1000_0012, 32'h0, 0, 0, 32'hffff_9abc, EXP_NONE);
        add_vector(OP_LHU, 32'h1000_0012, 32'h0, 0, 0, 32'h0000_9abc, EXP_NONE);
        add_vector(OP_LH,  32'h1000_0010, 32'h0, 0, 0, 32'hffff_f021, EXP_NONE);
        add_vector(OP_LBU, 32'h1000_0013, 32'h0, 0, 0, 32'h0000_009a, EXP_NONE);
        // AHB side with 0 to 3 wait states
        add_vector(OP_SW,  32'h2000_0008, 32'h1122_3344, 0, 0, 32'h0, EXP_NONE);
        add_vector(OP_SB,  32'h2000_0009, 32'h0000_00ab, 1, 0, 32'h0, EXP_NONE);
        add_vector(OP_SH,  32'h2000_000a, 32'h0000_cdef, 2, 0, 32'h0, EXP_NONE);
        add_vector(OP_LW,  32'h2000_0008, 32'h0, 3, 0, 32'hcdef_ab44, EXP_NONE);
        add_vector(OP_LB,  32'h2000_0009, 32'h0, 1, 0, 32'hffff_ffab, EXP_NONE);
        add_vector(OP_LHU, 32'h2000_000a, 32'h0, 0, 0, 32'h0000_cdef, EXP_NONE);
        add_vector(OP_LH,  32'h2000_000a, 32'h0, 2, 0, 32'hffff_cdef, EXP_NONE);
        add_vector(OP_LBU, 32'h2000_0008, 32'h0, 0, 0, 32'h0000_0044, EXP_NONE);
        add_vector(OP_LW,  32'h2000_0014, 32'h0, 1, 0, 32'h5a5a_0014, EXP_NONE);
        // misaligned in both regions
        add_vector(OP_LH,  32'h1000_0011, 32'h0, 0, 0, 32'h0, EXP_LOAD_MISALIGNED);
        add_vector(OP_SW,  32'h1000_0012, 32'h0, 0, 0, 32'h0, EXP_STORE_MISALIGNED);
        add_vector(OP_LW,  32'h2000_0001, 32'h0, 0, 0, 32'h0, EXP_LOAD_MISALIGNED);
        add_vector(OP_SH,  32'h2000_0003, 32'h0, 0, 0, 32'h0, EXP_STORE_MISALIGNED);
        // error responses, then stuck slaves each followed by a normal access
        add_vector(OP_LW,  32'h2000_0008, 32'h0, 1, 1, 32'h0, EXP_LOAD_ACCESS_FAULT);
        add_vector(OP_SB,  32'h2000_0004, 32'h0000_0077, 0, 1, 32'h0, EXP_STORE_ACCESS_FAULT);
        add_vector(OP_SW,  32'h2000_0010, 32'h0bad_0bad, 200, 0, 32'h0, EXP_STORE_ACCESS_FAULT);
        add_vector(OP_LW,  32'h2000_0008, 32'h0, 0, 0, 32'hcdef_ab44, EXP_NONE);
        add_vector(OP_LH,  32'h2000_0002, 32'h0, 200, 0, 32'h0, EXP_LOAD_ACCESS_FAULT);
        add_vector(OP_LBU, 32'h2000_000b, 32'h0, 2, 0, 32'h0000_00cd, EXP_NONE);

        fork
            begin
                repeat (vectors.size() * (BUS_TIMEOUT + 8) + 20) @(posedge clk);
                $display("watchdog expired: the tests did not finish in the expected time");
                $display("TESTBENCH FAILED");
                $fatal(1, "watchdog timeout");
            end
        join_none

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        foreach (vectors[i]) begin
            v         = vectors[i];
            size      = size_of(v.op);
            bad_align = ((size == HSIZE_HALF) && v.addr[0]) ||
                        ((size == HSIZE_WORD) && (v.addr[1:0] != 2'b00));
            to_spm    = (v.addr[31:28] == 4'h1);
            stuck     = (v.waits > BUS_TIMEOUT);
            // stuck slave: BUS_TIMEOUT low cycles, the timeout cycle, then finish
            if (bad_align || to_spm) begin
                want_lat = 2;
            end else if (stuck) begin
                want_lat = BUS_TIMEOUT + 4;
            end else begin
                want_lat = 3 + int'(v.waits) + int'(v.err);
            end

            @(posedge clk);
            slave_waits <= v.waits;
            slave_err   <= v.err;
            req <= '{valid: 1'b1, op: v.op, addr: v.addr, store_data: v.sdata};
            lat        = 0;
            saw_nonseq = 1'b0;

            do begin
                @(negedge clk);
                lat++;
                check_equal("bus_wait", bus_wait, lat < want_lat);
                check_equal("hburst", hburst, 0);
                check_equal("hmastlock", hmastlock, 0);
                if (ahb_out.htrans == HTRANS_NONSEQ) begin
                    saw_nonseq = 1'b1;
                    check_equal("haddr", ahb_out.haddr, v.addr);
                    check_equal("hsize", ahb_out.hsize, size);
                    check_equal("hwrite", ahb_out.hwrite, is_store_op(v.op));
                end
            end while (!rsp.done);

            check_equal("exp", rsp.exp, v.exp);
            check_equal("nonseq_seen", saw_nonseq, !bad_align && !to_spm);
            check_equal("done_latency", lat, want_lat);
            if (!stuck && is_store_op(v.op) && saw_nonseq) begin
                check_equal("hwdata", ahb_out.hwdata, lane_data(size, v.sdata));
            end
            if (!is_store_op(v.op) && (v.exp == EXP_NONE)) begin
                check_equal("load_data", rsp.load_data, v.load);
            end

            @(posedge clk);
            req.valid <= 1'b0;
            @(negedge clk);
            check_equal("bus_wait", bus_wait, 0);
            check_equal("done", rsp.done, 0);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
